/* verilog/adcfifo_defines.svh */
`ifndef ADCFIFO_DEFINES_SVH
`define ADCFIFO_DEFINES_SVH

// Power-of-two FIFO geometry
`define FIFO_DEPTH 64
`define FIFO_AW    6

// Datapath widths
`define ADC_W      12
`define BYTECNT_W  7
`define THRESH_W   17

// Stream segment threshold after reset
`define THRESH_RESET 17'd65536

// Register map
`define ADCREAD_ADDR             8'd3
`define FIFO_STAT                8'd16
`define FIFO_STATE               8'd17
`define FIFO_FIRST_ERROR         8'd18
`define FIFO_FIRST_ERROR_STATE   8'd19
`define DEBUG_FIFO_READS         8'd20
`define DEBUG_FIFO_READS_FREEZE  8'd21
`define STREAM_SEGMENT_THRESHOLD 8'd22
`define ADC_LOW_RES              8'd23
`define FIFO_UNDERFLOW_COUNT     8'd24
`define FIFO_NO_UNDERFLOW_ERROR  8'd25
`define CAPTURE_DONE             8'd26
`define FAST_FIFO_READ_MODE      8'd27

`endif

/* verilog/adcfifo_pkg.sv */
package adcfifo_pkg;

  // One FIFO entry, seen as a sample or as two bytes
  typedef union packed {
    struct packed {
      logic [3:0]  pad;   // Always zero
      logic [11:0] value; // Raw ADC code
    } sample;
    logic [1:0][7:0] bytes; // bytes[0] is the low byte
  } fifo_word_u;

  typedef enum logic [2:0] {
    FS_IDLE      = 3'd0,
    FS_FILLING   = 3'd1,
    FS_DONE      = 3'd2,
    FS_OVERFLOW  = 3'd3,
    FS_UNDERFLOW = 3'd4
  } fifo_state_e;

  // Bit 0 overflow, 1 underflow, 2 threshold, 3 empty, 4 full
  typedef logic [15:0] fifo_stat_t;

endpackage

/* verilog/reg_adcfifo.sv */
`timescale 1ns/1ns
`include "adcfifo_defines.svh"

module reg_adcfifo (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  logic [7:0]               reg_address,
  input  logic [`BYTECNT_W-1:0]    reg_bytecnt,
  input  logic [7:0]               reg_datai,
  input  logic                     reg_read,
  input  logic                     reg_write,
  input  logic [7:0]               head_byte,
  input  adcfifo_pkg::fifo_stat_t  fifo_stat,
  input  adcfifo_pkg::fifo_state_e fifo_state,
  input  adcfifo_pkg::fifo_stat_t  first_error_stat,
  input  adcfifo_pkg::fifo_state_e first_error_state,
  input  logic [7:0]               underflow_count,
  input  logic                     capture_done,
  input  logic [31:0]              fifo_read_count,
  input  logic [31:0]              fifo_read_count_freeze,
  output logic [7:0]               reg_datao,
  output logic                     fifo_rd_en,
  output logic                     byte_sel,
  output logic                     low_res,
  output logic                     low_res_lsb,
  output logic [`THRESH_W-1:0]     stream_segment_threshold,
  output logic                     clear_fifo_errors,
  output logic                     no_underflow_errors
);

  logic        fast_fifo_read_mode;
  logic        reg_read_r;       // reg_read one cycle late
  logic        fifo_rd_en_reg;   // Slow mode pop strobe
  logic        last_byte;
  logic        read_rise;
  logic        pop_cond;
  logic [31:0] thresh_pad;

  assign thresh_pad = {{(32 - `THRESH_W){1'b0}}, stream_segment_threshold};

  // Low-res mode keeps one byte per word
  assign byte_sel  = low_res ? ~low_res_lsb : reg_bytecnt[0];
  assign last_byte = low_res | reg_bytecnt[0];

  assign read_rise = reg_read & ~reg_read_r;
  assign pop_cond  = read_rise && (reg_address == `ADCREAD_ADDR) && last_byte;

  // Fast mode saves a cycle by popping on the rising edge itself
  assign fifo_rd_en = fast_fifo_read_mode ? pop_cond : fifo_rd_en_reg;

  always_comb begin
    reg_datao = 8'h00;
    if (reg_read) begin
      case (reg_address)
        `ADCREAD_ADDR:             reg_datao = head_byte;
        `FIFO_STAT:                reg_datao = fifo_stat[{reg_bytecnt[0], 3'b000} +: 8];
        `FIFO_STATE:               reg_datao = {5'b0, fifo_state};
        `FIFO_FIRST_ERROR:         reg_datao = first_error_stat[{reg_bytecnt[0], 3'b000} +: 8];
        `FIFO_FIRST_ERROR_STATE:   reg_datao = {5'b0, first_error_state};
        `DEBUG_FIFO_READS:
          reg_datao = fifo_read_count[{reg_bytecnt[1:0], 3'b000} +: 8];
        `DEBUG_FIFO_READS_FREEZE:
          reg_datao = fifo_read_count_freeze[{reg_bytecnt[1:0], 3'b000} +: 8];
        `STREAM_SEGMENT_THRESHOLD: reg_datao = thresh_pad[{reg_bytecnt[1:0], 3'b000} +: 8];
        `ADC_LOW_RES:              reg_datao = {6'b0, low_res_lsb, low_res};
        `FIFO_UNDERFLOW_COUNT:     reg_datao = underflow_count;
        `FIFO_NO_UNDERFLOW_ERROR:  reg_datao = {7'b0, no_underflow_errors};
        `CAPTURE_DONE:             reg_datao = {7'b0, capture_done};
        `FAST_FIFO_READ_MODE:      reg_datao = {7'b0, fast_fifo_read_mode};
        default:                   reg_datao = 8'h00;
      endcase
    end
  end

  // Writable configuration
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res                  <= 1'b0;
      low_res_lsb              <= 1'b0;
      clear_fifo_errors        <= 1'b0;
      no_underflow_errors      <= 1'b0;
      stream_segment_threshold <= `THRESH_RESET;
    end else if (reg_write) begin
      case (reg_address)
        `ADC_LOW_RES:             {low_res_lsb, low_res} <= reg_datai[1:0];
        `FIFO_STAT:               clear_fifo_errors <= reg_datai[0]; // Held until rewritten
        `FIFO_NO_UNDERFLOW_ERROR: no_underflow_errors <= reg_datai[0];
        `STREAM_SEGMENT_THRESHOLD: begin
          case (reg_bytecnt[1:0])
            2'd0:    stream_segment_threshold[7:0]  <= reg_datai;
            2'd1:    stream_segment_threshold[15:8] <= reg_datai;
            2'd2:    stream_segment_threshold[16]   <= reg_datai[0];
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // Fast read mode drops out on any other register write
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fast_fifo_read_mode <= 1'b0;
    end else if (reg_write) begin
      if (reg_address == `FAST_FIFO_READ_MODE)
        fast_fifo_read_mode <= reg_datai[0];
      else
        fast_fifo_read_mode <= 1'b0;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_read_r     <= 1'b0;
      fifo_rd_en_reg <= 1'b0;
    end else begin
      reg_read_r     <= reg_read;
      fifo_rd_en_reg <= pop_cond; // One cycle after the read edge
    end
  end

endmodule

/* verilog/adc_sample_fifo.sv */
`timescale 1ns/1ns
`include "adcfifo_defines.svh"

module adc_sample_fifo (
  input  logic                 clk_usb,
  input  logic                 reset,
  input  logic [`ADC_W-1:0]    adc_data,
  input  logic                 adc_valid,
  input  logic                 fifo_rd_en,
  input  logic                 byte_sel,
  input  logic [`THRESH_W-1:0] stream_segment_threshold,
  output logic [7:0]           head_byte,
  output logic                 empty,
  output logic                 full,
  output logic                 thresh_hit,
  output logic                 write_attempt,
  output logic                 pop_empty
);

  adcfifo_pkg::fifo_word_u mem [`FIFO_DEPTH];

  adcfifo_pkg::fifo_word_u wr_word;
  adcfifo_pkg::fifo_word_u head_word;

  logic [`FIFO_AW-1:0] wr_ptr;
  logic [`FIFO_AW-1:0] rd_ptr;
  logic [`FIFO_AW:0]   count;
  logic                do_write;
  logic                do_pop;

  assign empty = (count == '0);
  assign full  = (count == `FIFO_DEPTH);

  assign do_write = adc_valid & ~full;
  assign do_pop   = fifo_rd_en & ~empty;

  // Single-cycle indications for the tracker
  assign write_attempt = adc_valid & full;
  assign pop_empty     = fifo_rd_en & empty;

  assign thresh_hit = ({{(`THRESH_W - `FIFO_AW - 1){1'b0}}, count} >= stream_segment_threshold);

  always_comb begin
    wr_word.sample.pad   = 4'h0;
    wr_word.sample.value = adc_data;
  end

  // Head word split into bytes
  assign head_word = mem[rd_ptr];
  assign head_byte = head_word.bytes[byte_sel];

  // Sample storage
  always_ff @(posedge clk_usb) begin
    if (do_write)
      mem[wr_ptr] <= wr_word;
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write)
        wr_ptr <= wr_ptr + 1'b1; // Wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

endmodule

/* verilog/fifo_error_tracker.sv */
`timescale 1ns/1ns

module fifo_error_tracker (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  logic                     adc_valid_drop,
  input  logic                     pop_empty,
  input  logic                     fifo_rd_en,
  input  logic                     empty,
  input  logic                     full,
  input  logic                     thresh_hit,
  input  logic                     capture_done,
  input  logic                     clear_fifo_errors,
  input  logic                     no_underflow_errors,
  output adcfifo_pkg::fifo_stat_t  fifo_stat,
  output adcfifo_pkg::fifo_state_e fifo_state,
  output adcfifo_pkg::fifo_stat_t  first_error_stat,
  output adcfifo_pkg::fifo_state_e first_error_state,
  output logic [7:0]               underflow_count,
  output logic [31:0]              fifo_read_count,
  output logic [31:0]              fifo_read_count_freeze
);

  logic overflow;
  logic underflow;
  logic overflow_nxt;
  logic underflow_nxt;
  logic first_seen;   // Snapshot taken since last clear

  function automatic adcfifo_pkg::fifo_state_e state_of(input logic ovf, input logic unf,
                                                        input logic done, input logic emp);
    if (ovf)       return adcfifo_pkg::FS_OVERFLOW;
    else if (unf)  return adcfifo_pkg::FS_UNDERFLOW;
    else if (done) return adcfifo_pkg::FS_DONE;
    else if (!emp) return adcfifo_pkg::FS_FILLING;
    else           return adcfifo_pkg::FS_IDLE;
  endfunction

  assign overflow_nxt  = overflow | adc_valid_drop;
  assign underflow_nxt = underflow | (pop_empty & ~no_underflow_errors); // Masked when asked

  assign fifo_stat  = {11'b0, full, empty, thresh_hit, underflow, overflow};
  assign fifo_state = state_of(overflow, underflow, capture_done, empty);

  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      overflow          <= 1'b0;
      underflow         <= 1'b0;
      first_seen        <= 1'b0;
      first_error_stat  <= '0;
      first_error_state <= adcfifo_pkg::FS_IDLE;
      underflow_count   <= 8'd0;
    end else begin
      overflow  <= overflow_nxt;
      underflow <= underflow_nxt;
      // Capture what the status looks like once the error lands
      if ((overflow_nxt | underflow_nxt) && !first_seen) begin
        first_seen        <= 1'b1;
        first_error_stat  <= {11'b0, full, empty, thresh_hit, underflow_nxt, overflow_nxt};
        first_error_state <= state_of(overflow_nxt, underflow_nxt, capture_done, empty);
      end
      if (pop_empty && underflow_count != 8'hff)
        underflow_count <= underflow_count + 8'd1; // Saturates
    end
  end

  // Debug read counters
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fifo_read_count        <= 32'd0;
      fifo_read_count_freeze <= 32'd0;
    end else begin
      if (fifo_rd_en)
        fifo_read_count <= fifo_read_count + 32'd1;
      if (!(overflow | underflow))
        fifo_read_count_freeze <= fifo_read_count;
    end
  end

endmodule

/* verilog/adc_capture_top.sv */
`timescale 1ns/1ns
`include "adcfifo_defines.svh"

module adc_capture_top (
  input  logic                     clk_usb,
  input  logic                     reset,
  input  logic [7:0]               reg_address,
  input  logic [`BYTECNT_W-1:0]    reg_bytecnt,
  input  logic [7:0]               reg_datai,
  input  logic                     reg_read,
  input  logic                     reg_write,
  input  logic [`ADC_W-1:0]        adc_data,
  input  logic                     adc_valid,
  input  logic                     capture_done,
  output logic [7:0]               reg_datao,
  output adcfifo_pkg::fifo_stat_t  fifo_stat,
  output adcfifo_pkg::fifo_state_e fifo_state
);

  logic                     fifo_rd_en;
  logic                     byte_sel;
  logic                     low_res;
  logic                     low_res_lsb;
  logic [`THRESH_W-1:0]     stream_segment_threshold;
  logic                     clear_fifo_errors;
  logic                     no_underflow_errors;
  logic [7:0]               head_byte;
  logic                     empty;
  logic                     full;
  logic                     thresh_hit;
  logic                     write_attempt;
  logic                     pop_empty;
  adcfifo_pkg::fifo_stat_t  first_error_stat;
  adcfifo_pkg::fifo_state_e first_error_state;
  logic [7:0]               underflow_count;
  logic [31:0]              fifo_read_count;
  logic [31:0]              fifo_read_count_freeze;

  reg_adcfifo u_reg (
    .clk_usb, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_read, .reg_write,
    .head_byte, .fifo_stat, .fifo_state, .first_error_stat, .first_error_state,
    .underflow_count, .capture_done, .fifo_read_count, .fifo_read_count_freeze,
    .reg_datao, .fifo_rd_en, .byte_sel, .low_res, .low_res_lsb,
    .stream_segment_threshold, .clear_fifo_errors, .no_underflow_errors
  );

  adc_sample_fifo u_fifo (
    .clk_usb, .reset, .adc_data, .adc_valid, .fifo_rd_en, .byte_sel,
    .stream_segment_threshold, .head_byte, .empty, .full, .thresh_hit,
    .write_attempt, .pop_empty
  );

  fifo_error_tracker u_track (
    .clk_usb, .reset, .adc_valid_drop(write_attempt), .pop_empty, .fifo_rd_en,
    .empty, .full, .thresh_hit, .capture_done, .clear_fifo_errors, .no_underflow_errors,
    .fifo_stat, .fifo_state, .first_error_stat, .first_error_state, .underflow_count,
    .fifo_read_count, .fifo_read_count_freeze
  );

endmodule

/* sim/tb_adc_capture.sv */
`timescale 1ns/1ns
`include "adcfifo_defines.svh"

module tb_adc_capture;

  logic                     clk_usb = 1'b0;
  logic                     reset;
  logic [7:0]               reg_address;
  logic [`BYTECNT_W-1:0]    reg_bytecnt;
  logic [7:0]               reg_datai;
  logic                     reg_read;
  logic                     reg_write;
  logic [`ADC_W-1:0]        adc_data;
  logic                     adc_valid;
  logic                     capture_done;
  logic [7:0]               reg_datao;
  adcfifo_pkg::fifo_stat_t  fifo_stat;
  adcfifo_pkg::fifo_state_e fifo_state;

  adcfifo_pkg::fifo_word_u  model_q[$];   // Expected FIFO contents
  logic [`THRESH_W-1:0]     thresh = `THRESH_RESET;
  logic [31:0]              lfsr = 32'hbd8b_d8e3;
  int                       errors = 0;
  int                       mark = 0;
  int                       tests = 0;

  // Pending compare for the checker process
  int                       kind = 0; // 1 byte 2 status 3 state
  logic [7:0]               exp_byte;
  adcfifo_pkg::fifo_stat_t  exp_stat;
  adcfifo_pkg::fifo_state_e exp_state;
  string                    what;

  // Rough bus operations per test at 20 cycles each
  localparam int TOTAL_OPS = 10 + 60 + 240 + 110 + 210 + 30;

  adc_capture_top i_dut (.*);

  always #5 clk_usb = ~clk_usb;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Low-res picks one byte by lsb while full res walks low then high
  function automatic logic [7:0] ref_read_byte(input adcfifo_pkg::fifo_word_u word,
                                               input logic lr, input logic lsb,
                                               input logic [`BYTECNT_W-1:0] bc);
    if (lr)
      return lsb ? word.bytes[0] : word.bytes[1];
    return bc[0] ? word.bytes[1] : word.bytes[0];
  endfunction

  function automatic adcfifo_pkg::fifo_stat_t model_stat(input logic ovf, input logic unf);
    adcfifo_pkg::fifo_stat_t s;
    s = '0;
    s[0] = ovf;
    s[1] = unf;
    s[2] = (`THRESH_W'(model_q.size()) >= thresh);
    s[3] = (model_q.size() == 0);
    s[4] = (model_q.size() == `FIFO_DEPTH);
    return s;
  endfunction

  function automatic adcfifo_pkg::fifo_state_e model_state(input logic ovf, input logic unf);
    if (ovf)                    return adcfifo_pkg::FS_OVERFLOW;
    else if (unf)               return adcfifo_pkg::FS_UNDERFLOW;
    else if (capture_done)      return adcfifo_pkg::FS_DONE;
    else if (model_q.size() > 0) return adcfifo_pkg::FS_FILLING;
    else                        return adcfifo_pkg::FS_IDLE;
  endfunction

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error reg_datao (%0s): got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_stat(input string name, input adcfifo_pkg::fifo_stat_t got,
                            input adcfifo_pkg::fifo_stat_t exp);
    if (got !== exp) begin
      $display("error %0s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_state(input string name, input adcfifo_pkg::fifo_state_e got,
                             input adcfifo_pkg::fifo_state_e exp);
    if (got !== exp) begin
      $display("error %0s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Samples in the drive cycle just before the next rising edge
  always begin
    @(negedge clk_usb);
    #4;
    case (kind)
      1:       check_byte(what, reg_datao, exp_byte);
      2:       check_stat(what, fifo_stat, exp_stat);
      3:       check_state(what, fifo_state, exp_state);
      default: ;
    endcase
    kind = 0;
  end

  task automatic reg_wr(input logic [7:0] addr, input logic [`BYTECNT_W-1:0] bc,
                        input logic [7:0] data);
    @(negedge clk_usb);
    reg_address = addr;
    reg_bytecnt = bc;
    reg_datai   = data;
    reg_write   = 1'b1;
    @(negedge clk_usb);
    reg_write = 1'b0;
  endtask

  // One-cycle read pulse then two idle cycles
  task automatic reg_rd(input logic [7:0] addr, input logic [`BYTECNT_W-1:0] bc,
                        input logic [7:0] exp, input string name);
    @(negedge clk_usb);
    reg_address = addr;
    reg_bytecnt = bc;
    reg_read    = 1'b1;
    exp_byte    = exp;
    what        = name;
    kind        = (name == "") ? 0 : 1; // Empty name skips the check
    @(negedge clk_usb);
    reg_read = 1'b0;
    repeat (2) @(negedge clk_usb);
  endtask

  task automatic push_sample(input logic [`ADC_W-1:0] d);
    adcfifo_pkg::fifo_word_u w;
    w.sample.pad   = 4'h0;
    w.sample.value = d;
    @(negedge clk_usb);
    adc_data  = d;
    adc_valid = 1'b1;
    if (model_q.size() < `FIFO_DEPTH)
      model_q.push_back(w); // Full FIFO drops the sample
    @(negedge clk_usb);
    adc_valid = 1'b0;
  endtask

  task automatic fill(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = rand_bits(`ADC_W);
      push_sample(r[`ADC_W-1:0]);
    end
  endtask

  task automatic drain(input logic lr, input logic lsb);
    adcfifo_pkg::fifo_word_u w;
    while (model_q.size() > 0) begin
      w = model_q.pop_front();
      reg_rd(`ADCREAD_ADDR, 0, ref_read_byte(w, lr, lsb, 0), "ADC read");
      if (!lr)
        reg_rd(`ADCREAD_ADDR, 1, ref_read_byte(w, lr, lsb, 1), "ADC read");
    end
  endtask

  task automatic expect_status(input logic ovf, input logic unf);
    @(negedge clk_usb);
    exp_stat = model_stat(ovf, unf);
    what     = "fifo_stat";
    kind     = 2;
    @(negedge clk_usb);
    exp_state = model_state(ovf, unf);
    what      = "fifo_state";
    kind      = 3;
    @(negedge clk_usb);
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0s: %0d errors", name, errors - mark);
    mark = errors;
  endtask

  initial begin
    #(TOTAL_OPS * 20 * 10);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0]             r;
    int                      n;
    adcfifo_pkg::fifo_stat_t s;
    adcfifo_pkg::fifo_word_u w;
    reset        = 1'b1;
    reg_address  = '0;
    reg_bytecnt  = '0;
    reg_datai    = '0;
    reg_read     = 1'b0;
    reg_write    = 1'b0;
    adc_data     = '0;
    adc_valid    = 1'b0;
    capture_done = 1'b0;
    repeat (10) @(posedge clk_usb);
    @(negedge clk_usb);
    reset = 1'b0;

    reg_rd(`STREAM_SEGMENT_THRESHOLD, 0, 8'h00, "threshold byte 0");
    reg_rd(`STREAM_SEGMENT_THRESHOLD, 1, 8'h00, "threshold byte 1");
    reg_rd(`STREAM_SEGMENT_THRESHOLD, 2, 8'h01, "threshold byte 2");
    reg_rd(`ADC_LOW_RES, 0, 8'h00, "low_res");
    reg_rd(`FIFO_STAT, 0, 8'h08, "fifo_stat readback");
    reg_rd(`FIFO_STATE, 0, {5'b0, adcfifo_pkg::FS_IDLE}, "fifo_state readback");
    reg_rd(`FIFO_UNDERFLOW_COUNT, 0, 8'h00, "underflow_count");
    expect_status(1'b0, 1'b0);
    end_test("reset values");

    r = rand_bits(5);
    thresh = `THRESH_W'(r[4:0]) + 1'b1; // 1 to 32 samples
    reg_wr(`STREAM_SEGMENT_THRESHOLD, 0, thresh[7:0]);
    reg_wr(`STREAM_SEGMENT_THRESHOLD, 1, thresh[15:8]);
    reg_wr(`STREAM_SEGMENT_THRESHOLD, 2, {7'b0, thresh[16]});
    reg_rd(`STREAM_SEGMENT_THRESHOLD, 0, thresh[7:0], "threshold byte 0");
    reg_rd(`STREAM_SEGMENT_THRESHOLD, 2, {7'b0, thresh[16]}, "threshold byte 2");
    reg_wr(`ADC_LOW_RES, 0, 8'h03);
    reg_rd(`ADC_LOW_RES, 0, 8'h03, "low_res and low_res_lsb");
    reg_wr(`FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01);
    reg_rd(`FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01, "no_underflow_errors");
    reg_wr(`FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00);
    reg_wr(`ADC_LOW_RES, 0, 8'h00);
    fill(int'(thresh) - 1);
    expect_status(1'b0, 1'b0); // One short of the threshold
    fill(1);
    expect_status(1'b0, 1'b0);
    drain(1'b0, 1'b0);
    end_test("register access");

    r = rand_bits(5);
    n = int'(r[4:0]) + 1;
    fill(n);
    drain(1'b0, 1'b0);
    expect_status(1'b0, 1'b0);
    fill(n);
    reg_wr(`ADC_LOW_RES, 0, 8'h03);
    drain(1'b1, 1'b1);
    fill(n);
    reg_wr(`ADC_LOW_RES, 0, 8'h01);
    drain(1'b1, 1'b0);
    reg_wr(`ADC_LOW_RES, 0, 8'h00);
    expect_status(1'b0, 1'b0);
    end_test("streaming reads");

    fill(n);
    reg_wr(`FAST_FIFO_READ_MODE, 0, 8'h01);
    reg_rd(`FAST_FIFO_READ_MODE, 0, 8'h01, "fast_fifo_read_mode");
    drain(1'b0, 1'b0);
    expect_status(1'b0, 1'b0);
    fill(1);
    w = model_q.pop_front();
    @(negedge clk_usb);
    reg_address = `ADCREAD_ADDR;
    reg_bytecnt = 1;
    reg_read    = 1'b1;
    exp_byte    = ref_read_byte(w, 1'b0, 1'b0, 1);
    what        = "fast read";
    kind        = 1;
    @(negedge clk_usb);
    reg_read = 1'b0;
    exp_stat = model_stat(1'b0, 1'b0); // Popped at the end of the pulse
    what     = "fifo_stat";
    kind     = 2;
    repeat (2) @(negedge clk_usb);
    reg_wr(`FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00); // Any other write leaves fast mode
    reg_rd(`FAST_FIFO_READ_MODE, 0, 8'h00, "fast_fifo_read_mode");
    end_test("fast read mode");

    fill(`FIFO_DEPTH + 3);
    expect_status(1'b1, 1'b0);
    s = model_stat(1'b1, 1'b0);
    reg_rd(`FIFO_FIRST_ERROR, 0, s[7:0], "first_error_stat");
    reg_rd(`FIFO_FIRST_ERROR_STATE, 0, {5'b0, adcfifo_pkg::FS_OVERFLOW}, "first_error_state");
    drain(1'b0, 1'b0);
    expect_status(1'b1, 1'b0);
    reg_wr(`FIFO_STAT, 0, 8'h01);
    reg_wr(`FIFO_STAT, 0, 8'h00);
    expect_status(1'b0, 1'b0);
    end_test("overflow");

    reg_wr(`FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01);
    reg_rd(`ADCREAD_ADDR, 1, 8'h00, "");
    reg_rd(`ADCREAD_ADDR, 1, 8'h00, "");
    reg_rd(`FIFO_UNDERFLOW_COUNT, 0, 8'h02, "underflow_count");
    expect_status(1'b0, 1'b0); // Masked so the flag stays clear
    reg_wr(`FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00);
    reg_rd(`ADCREAD_ADDR, 1, 8'h00, "");
    reg_rd(`FIFO_UNDERFLOW_COUNT, 0, 8'h03, "underflow_count");
    expect_status(1'b0, 1'b1);
    reg_wr(`FIFO_STAT, 0, 8'h01);
    reg_wr(`FIFO_STAT, 0, 8'h00);
    @(negedge clk_usb);
    capture_done = 1'b1;
    expect_status(1'b0, 1'b0);
    reg_rd(`CAPTURE_DONE, 0, 8'h01, "capture_done");
    end_test("underflow and done");

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* all.f */
+incdir+verilog
verilog/adcfifo_pkg.sv
verilog/reg_adcfifo.sv
verilog/adc_sample_fifo.sv
verilog/fifo_error_tracker.sv
verilog/adc_capture_top.sv
sim/tb_adc_capture.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run, pass only when the testbench reports no errors
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module tb_adc_capture -Mdir obj_dir \
  -o tb_adc_capture || { echo "Build failed"; exit 1; }
out="$(./obj_dir/tb_adc_capture)"
echo "$out"
echo "$out" | grep -qx "Finished with no errors" && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
